// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_datapath -o tb_datapath
	@out="$$(./obj_dir/tb_datapath)"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

// ==== sim.f ====
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/hazard_unit.sv
verilog/datapath.sv
test/tb_datapath.sv

// ==== test/tb_datapath.sv ====
module tb_datapath import core_pkg::*; ();

    localparam int prog_len        = 200;
    localparam int mem_words       = 256;
    localparam int region_base     = 32'h300;  // 16 data words from here
    localparam int watchdog_cycles = 20 * prog_len;

    logic      clk;
    logic      reset;
    logic      inst_stall = 1'b0;
    logic      data_stall = 1'b0;
    word_t     rom_data, ram_data, rom_addr, ram_addr, ram_wdata;
    logic      rom_ce, ram_ce, ram_we, stall_all, dbg_wen;
    word_t     dbg_pc, dbg_wdata;
    reg_addr_t dbg_wnum;

    word_t     rom [0:mem_words-1];
    word_t     ram [0:mem_words-1];
    word_t     model_ram [0:mem_words-1];
    word_t     model_regs [0:31];
    word_t     exp_pc [0:prog_len-1];
    word_t     exp_idx [0:prog_len-1];
    word_t     exp_val [0:prog_len-1];
    int        exp_count, exp_stores, wb_count, store_count, errors;
    integer    seed;
    word_t     rnd;

    assign rom_data = rom[rom_addr[9:2]];
    assign ram_data = ram[ram_addr[9:2]];

    datapath datapath_inst (
        .clk_i               (clk),
        .reset_i             (reset),
        .rom_data_i          (rom_data),
        .ram_data_i          (ram_data),
        .inst_stall_i        (inst_stall),
        .data_stall_i        (data_stall),
        .rom_ce_o            (rom_ce),
        .rom_addr_o          (rom_addr),
        .ram_ce_o            (ram_ce),
        .ram_we_o            (ram_we),
        .ram_addr_o          (ram_addr),
        .ram_wdata_o         (ram_wdata),
        .stall_all_o         (stall_all),
        .debug_wb_pc_o       (dbg_pc),
        .debug_wb_rf_wen_o   (dbg_wen),
        .debug_wb_rf_wnum_o  (dbg_wnum),
        .debug_wb_rf_wdata_o (dbg_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t fill_word(input int i);
        return word_t'(i) * 32'h9e37_79b9 ^ 32'h5a5a_0f0f;
    endfunction

    function automatic word_t sext(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic reg_addr_t pick_reg(input word_t r);
        return reg_addr_t'(r % 7) + 5'd1;  // r1..r7
    endfunction

    function automatic logic [5:0] pick_funct(input word_t r);
        case (r % 6)
            0:       return fn_addu;
            1:       return fn_subu;
            2:       return fn_and;
            3:       return fn_or;
            4:       return fn_xor;
            default: return fn_slt;
        endcase
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    //////////////////////////////////////////
    // memories and stall inputs
    //////////////////////////////////////////

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mem_words; i++) begin
                ram[i] <= fill_word(i);
            end
        end else if (ram_ce && ram_we && !data_stall) begin  // store commits here
            ram[ram_addr[9:2]] <= ram_wdata;
            store_count++;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            inst_stall <= 1'b0;
            data_stall <= 1'b0;
        end else begin
            rnd = $random(seed);
            inst_stall <= (rnd[1:0] == 2'b00);  // about a quarter
            data_stall <= (rnd[3:2] == 2'b00);
        end
    end

    task automatic build_program();
        word_t r;
        word_t addr;
        int    kind;
        int    tgt;
        logic  prev_branch;
        for (int i = 0; i < mem_words; i++) begin
            rom[i] = nop_inst;
        end
        prev_branch = 1'b0;
        for (int i = 0; i < prog_len - 2; i++) begin
            r    = $random(seed);
            kind = int'(r[3:0]);
            if (kind >= 13 && (prev_branch || i > prog_len - 4)) kind = 6;  // no branch in a slot
            tgt  = i + 2 + int'(r[5:4]);
            if (tgt > prog_len - 2) tgt = prog_len - 2;
            addr = word_t'(region_base) + {26'd0, r[27:24], 2'b00};
            case (kind)
                0, 1, 2, 3, 4, 5: rom[i] = {op_special, pick_reg(r >> 8), pick_reg(r >> 12),
                                            pick_reg(r >> 16), 5'd0, pick_funct(r >> 20)};
                6:       rom[i] = {op_addiu, pick_reg(r >> 8), pick_reg(r >> 12), r[31:16]};
                7:       rom[i] = {op_ori, pick_reg(r >> 8), pick_reg(r >> 12), r[31:16]};
                8:       rom[i] = {op_lui, 5'd0, pick_reg(r >> 12), r[31:16]};
                9, 10:   rom[i] = {op_lw, 5'd0, pick_reg(r >> 12), addr[15:0]};
                11, 12:  rom[i] = {op_sw, 5'd0, pick_reg(r >> 12), addr[15:0]};
                13:      rom[i] = {op_beq, pick_reg(r >> 8), pick_reg(r >> 12), 16'(tgt - i - 1)};
                14:      rom[i] = {op_bne, pick_reg(r >> 8), pick_reg(r >> 12), 16'(tgt - i - 1)};
                default: rom[i] = {op_j, 26'(tgt)};
            endcase
            prev_branch = (kind >= 13);
        end
        rom[prog_len-2] = {op_j, 26'(prog_len - 2)};  // park here
        rom[prog_len-1] = nop_inst;
    endtask

    //////////////////////////////////////////
    // ISA model with one delay slot
    //////////////////////////////////////////

    task automatic run_model();
        word_t     pc, npc, nnpc, inst, a, b, res, addr;
        reg_addr_t dest;
        logic      wr;
        int        steps;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        for (int i = 0; i < mem_words; i++) model_ram[i] = fill_word(i);
        pc = reset_pc;
        npc = pc + 32'd4;
        steps = 0;
        while (pc != word_t'((prog_len - 2) * 4) && steps < 4 * prog_len) begin
            inst = rom[pc[9:2]];
            a    = model_regs[inst[25:21]];
            b    = model_regs[inst[20:16]];
            addr = a + sext(inst[15:0]);
            dest = (inst[31:26] == op_special) ? inst[15:11] : inst[20:16];
            nnpc = npc + 32'd4;
            wr   = 1'b1;
            res  = '0;
            case (inst[31:26])
                op_special: begin
                    case (inst[5:0])
                        fn_addu: res = a + b;
                        fn_subu: res = a - b;
                        fn_and:  res = a & b;
                        fn_or:   res = a | b;
                        fn_xor:  res = a ^ b;
                        fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                op_addiu: res = addr;
                op_ori:   res = a | {16'h0000, inst[15:0]};
                op_lui:   res = {inst[15:0], 16'h0000};
                op_lw:    res = model_ram[addr[9:2]];
                op_sw: begin
                    wr = 1'b0;
                    model_ram[addr[9:2]] = b;
                    exp_stores++;
                end
                op_beq, op_bne: begin
                    wr = 1'b0;
                    if ((a == b) ^ (inst[31:26] == op_bne)) nnpc = npc + (sext(inst[15:0]) << 2);
                end
                op_j: begin
                    wr   = 1'b0;
                    nnpc = {npc[31:28], inst[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dest != '0) begin
                model_regs[dest]   = res;
                exp_pc[exp_count]  = pc;
                exp_idx[exp_count] = {27'd0, dest};
                exp_val[exp_count] = res;
                exp_count++;
            end
            pc = npc;
            npc = nnpc;
            steps++;
        end
    endtask

    task automatic expect_idle_after_reset();
        check_value("rom_ce_o", word_t'(rom_ce), 32'd0);
        check_value("ram_ce_o", word_t'(ram_ce), 32'd0);
        check_value("ram_we_o", word_t'(ram_we), 32'd0);
        check_value("debug_wb_rf_wen_o", word_t'(dbg_wen), 32'd0);
        check_value("stall_all_o", word_t'(stall_all), 32'd0);
    endtask

    task automatic watch_writeback();
        if ((inst_stall || (ram_ce && data_stall)) && !stall_all) begin
            errors++;
            $display("stall_all_o low at %0t while fetch is stalled", $time);
        end
        if (dbg_wen) begin
            if (wb_count < exp_count) begin
                check_value("debug_wb_pc", dbg_pc, exp_pc[wb_count]);
                check_value("debug_wb_rf_wnum", {27'd0, dbg_wnum}, exp_idx[wb_count]);
                check_value("debug_wb_rf_wdata", dbg_wdata, exp_val[wb_count]);
            end else begin
                errors++;
                $display("register write at %0t beyond the end of the program", $time);
            end
            wb_count++;
        end
    endtask

    task automatic print_counts();
        $display("errors %0d, writebacks %0d of %0d, stores %0d of %0d",
                 errors, wb_count, exp_count, store_count, exp_stores);
    endtask

    initial begin
        reset       = 1'b1;
        seed        = 32'h2c07_e7fd;
        errors      = 0;
        wb_count    = 0;
        store_count = 0;
        exp_count   = 0;
        exp_stores  = 0;
        build_program();
        run_model();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        expect_idle_after_reset();
        fork
            forever @(negedge clk) watch_writeback();
        join_none
        wait (wb_count >= exp_count && store_count >= exp_stores);
        repeat (20) @(posedge clk);  // anything extra would show up here
        #10;  // mid-cycle, clear of both edges
        check_value("writeback count", word_t'(wb_count), word_t'(exp_count));
        check_value("store count", word_t'(store_count), word_t'(exp_stores));
        for (int i = 0; i < mem_words; i++) begin
            check_value($sformatf("ram[%0h]", i * 4), ram[i], model_ram[i]);
        end
        print_counts();
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * 40);
        $display("watchdog expired after %0d cycles before the program finished",
                 watchdog_cycles);
        print_counts();
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== verilog/core_pkg.sv ====
package core_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui,
        alu_pass
    } alu_op_t;

    // primary opcodes, inst[31:26]
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // special function codes, inst[5:0]
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

    localparam word_t reset_pc = 32'h0000_0000;
    localparam word_t nop_inst = 32'h0000_0000;  // sll $0, $0, 0

endpackage

// ==== verilog/datapath.sv ====
module datapath import core_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  word_t     rom_data_i,
    input  word_t     ram_data_i,
    input  logic      inst_stall_i,
    input  logic      data_stall_i,
    output logic      rom_ce_o,
    output word_t     rom_addr_o,
    output logic      ram_ce_o,
    output logic      ram_we_o,
    output word_t     ram_addr_o,
    output word_t     ram_wdata_o,
    output logic      stall_all_o,
    output word_t     debug_wb_pc_o,
    output logic      debug_wb_rf_wen_o,
    output reg_addr_t debug_wb_rf_wnum_o,
    output word_t     debug_wb_rf_wdata_o
);
    // hazard controls
    logic      fetch_hold, decode_hold, ex_bubble, mem_hold, wb_bubble;

    // fetch / decode
    word_t     id_pc, id_inst, branch_target;
    logic      branch_taken;
    reg_addr_t id_rs, id_rt;
    logic      id_rs_read, id_rt_read;

    // execute
    alu_op_t   ex_op;
    word_t     ex_a, ex_b, ex_store_data, ex_pc, ex_result;
    reg_addr_t ex_waddr;
    logic      ex_we, ex_load, ex_store;

    // memory
    word_t     mem_result, mem_store_data, mem_pc, mem_wdata;
    reg_addr_t mem_waddr;
    logic      mem_we, mem_load, mem_store;

    // writeback
    word_t     wb_wdata, wb_pc;
    reg_addr_t wb_waddr;
    logic      wb_we;

    assign debug_wb_pc_o       = wb_pc;
    assign debug_wb_rf_wen_o   = wb_we;
    assign debug_wb_rf_wnum_o  = wb_waddr;
    assign debug_wb_rf_wdata_o = wb_wdata;

    fetch_stage fetch_inst (
        .clk_i, .reset_i, .inst_stall_i, .rom_data_i, .rom_ce_o, .rom_addr_o,
        .fetch_hold_i    (fetch_hold),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .id_pc_o         (id_pc),
        .id_inst_o       (id_inst)
    );

    decode_stage decode_inst (
        .clk_i, .reset_i,
        .decode_hold_i   (decode_hold),
        .ex_bubble_i     (ex_bubble),
        .pc_i            (id_pc),
        .inst_i          (id_inst),
        .ex_we_i         (ex_we),
        .ex_waddr_i      (ex_waddr),
        .ex_wdata_i      (ex_result),
        .mem_we_i        (mem_we),
        .mem_waddr_i     (mem_waddr),
        .mem_wdata_i     (mem_wdata),
        .wb_we_i         (wb_we),
        .wb_waddr_i      (wb_waddr),
        .wb_wdata_i      (wb_wdata),
        .rs_o            (id_rs),
        .rt_o            (id_rt),
        .rs_read_o       (id_rs_read),
        .rt_read_o       (id_rt_read),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .ex_op_o         (ex_op),
        .ex_a_o          (ex_a),
        .ex_b_o          (ex_b),
        .ex_store_data_o (ex_store_data),
        .ex_waddr_o      (ex_waddr),
        .ex_we_o         (ex_we),
        .ex_load_o       (ex_load),
        .ex_store_o      (ex_store),
        .ex_pc_o         (ex_pc)
    );

    execute_stage execute_inst (
        .clk_i, .reset_i,
        .hold_i           (mem_hold),
        .op_i             (ex_op),
        .a_i              (ex_a),
        .b_i              (ex_b),
        .store_data_i     (ex_store_data),
        .waddr_i          (ex_waddr),
        .we_i             (ex_we),
        .load_i           (ex_load),
        .store_i          (ex_store),
        .pc_i             (ex_pc),
        .result_o         (ex_result),
        .mem_result_o     (mem_result),
        .mem_store_data_o (mem_store_data),
        .mem_waddr_o      (mem_waddr),
        .mem_we_o         (mem_we),
        .mem_load_o       (mem_load),
        .mem_store_o      (mem_store),
        .mem_pc_o         (mem_pc)
    );

    memory_stage memory_inst (
        .clk_i, .reset_i, .ram_data_i, .ram_ce_o, .ram_we_o, .ram_addr_o, .ram_wdata_o,
        .data_stall_i (wb_bubble),
        .result_i     (mem_result),
        .store_data_i (mem_store_data),
        .waddr_i      (mem_waddr),
        .we_i         (mem_we),
        .load_i       (mem_load),
        .store_i      (mem_store),
        .pc_i         (mem_pc),
        .mem_wdata_o  (mem_wdata),
        .wb_we_o      (wb_we),
        .wb_waddr_o   (wb_waddr),
        .wb_wdata_o   (wb_wdata),
        .wb_pc_o      (wb_pc)
    );

    hazard_unit hazard_inst (
        .inst_stall_i, .data_stall_i, .stall_all_o,
        .rs_i          (id_rs),
        .rt_i          (id_rt),
        .rs_read_i     (id_rs_read),
        .rt_read_i     (id_rt_read),
        .ex_waddr_i    (ex_waddr),
        .ex_load_i     (ex_load),
        .ram_ce_i      (ram_ce_o),
        .fetch_hold_o  (fetch_hold),
        .decode_hold_o (decode_hold),
        .ex_bubble_o   (ex_bubble),
        .mem_hold_o    (mem_hold),
        .wb_bubble_o   (wb_bubble)
    );

endmodule

// ==== verilog/decode_stage.sv ====
module decode_stage import core_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      decode_hold_i,
    input  logic      ex_bubble_i,
    input  word_t     pc_i,
    input  word_t     inst_i,
    input  logic      ex_we_i,
    input  reg_addr_t ex_waddr_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_we_i,
    input  reg_addr_t mem_waddr_i,
    input  word_t     mem_wdata_i,
    input  logic      wb_we_i,
    input  reg_addr_t wb_waddr_i,
    input  word_t     wb_wdata_i,
    output reg_addr_t rs_o,
    output reg_addr_t rt_o,
    output logic      rs_read_o,
    output logic      rt_read_o,
    output logic      branch_taken_o,
    output word_t     branch_target_o,
    output alu_op_t   ex_op_o,
    output word_t     ex_a_o,
    output word_t     ex_b_o,
    output word_t     ex_store_data_o,
    output reg_addr_t ex_waddr_o,
    output logic      ex_we_o,
    output logic      ex_load_o,
    output logic      ex_store_o,
    output word_t     ex_pc_o
);
    logic [5:0] opcode;
    logic [5:0] funct;
    word_t      imm_sext;
    word_t      pc_plus4;
    word_t      rf_rdata1;
    word_t      rf_rdata2;
    word_t      rs_val;
    word_t      rt_val;
    word_t      imm;
    alu_op_t    op;
    reg_addr_t  dest;
    logic       use_imm;
    logic       we;
    logic       load;
    logic       store;

    assign opcode   = inst_i[31:26];
    assign rs_o     = inst_i[25:21];
    assign rt_o     = inst_i[20:16];
    assign funct    = inst_i[5:0];
    assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
    assign pc_plus4 = pc_i + 32'd4;

    reg_file rf_inst (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .we_i     (wb_we_i),
        .waddr_i  (wb_waddr_i),
        .wdata_i  (wb_wdata_i),
        .raddr1_i (rs_o),
        .raddr2_i (rt_o),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    // youngest producer wins
    function automatic word_t forward(input reg_addr_t idx, input word_t rf_val);
        if (ex_we_i && ex_waddr_i == idx) return ex_wdata_i;
        if (mem_we_i && mem_waddr_i == idx) return mem_wdata_i;
        if (wb_we_i && wb_waddr_i == idx) return wb_wdata_i;
        return rf_val;
    endfunction

    always_comb begin
        rs_val = forward(rs_o, rf_rdata1);
        rt_val = forward(rt_o, rf_rdata2);
    end

    always_comb begin
        rs_read_o       = 1'b0;
        rt_read_o       = 1'b0;
        op              = alu_pass;
        imm             = imm_sext;
        use_imm         = 1'b1;
        dest            = rt_o;
        we              = 1'b0;
        load            = 1'b0;
        store           = 1'b0;
        branch_taken_o  = 1'b0;
        branch_target_o = pc_plus4 + {imm_sext[29:0], 2'b00};
        case (opcode)
            op_special: begin
                rs_read_o = 1'b1;
                rt_read_o = 1'b1;
                use_imm   = 1'b0;
                dest      = inst_i[15:11];
                we        = 1'b1;
                case (funct)
                    fn_addu: op = alu_add;
                    fn_subu: op = alu_sub;
                    fn_and:  op = alu_and;
                    fn_or:   op = alu_or;
                    fn_xor:  op = alu_xor;
                    fn_slt:  op = alu_slt;
                    default: we = 1'b0;  // nop lands here
                endcase
            end
            op_addiu: begin
                rs_read_o = 1'b1;
                op        = alu_add;
                we        = 1'b1;
            end
            op_ori: begin
                rs_read_o = 1'b1;
                op        = alu_or;
                imm       = {16'h0000, inst_i[15:0]};
                we        = 1'b1;
            end
            op_lui: begin
                op = alu_lui;
                we = 1'b1;
            end
            op_lw: begin
                rs_read_o = 1'b1;
                op        = alu_add;
                we        = 1'b1;
                load      = 1'b1;
            end
            op_sw: begin
                rs_read_o = 1'b1;
                rt_read_o = 1'b1;
                op        = alu_add;
                store     = 1'b1;
            end
            op_beq, op_bne: begin
                rs_read_o      = 1'b1;
                rt_read_o      = 1'b1;
                branch_taken_o = (rs_val == rt_val) ^ (opcode == op_bne);
            end
            op_j: begin
                branch_taken_o  = 1'b1;
                branch_target_o = {pc_plus4[31:28], inst_i[25:0], 2'b00};
            end
            default: ;
        endcase
        if (dest == '0) we = 1'b0;
    end

    //////////////////////////////////////////
    // decode to execute register
    //////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i || ex_bubble_i) begin
            ex_we_o    <= 1'b0;
            ex_load_o  <= 1'b0;
            ex_store_o <= 1'b0;
        end else if (!decode_hold_i) begin
            ex_we_o    <= we;
            ex_load_o  <= load;
            ex_store_o <= store;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!decode_hold_i) begin
            ex_op_o         <= op;
            ex_a_o          <= rs_val;
            ex_b_o          <= use_imm ? imm : rt_val;
            ex_store_data_o <= rt_val;
            ex_waddr_o      <= dest;
            ex_pc_o         <= pc_i;
        end
    end

endmodule

// ==== verilog/execute_stage.sv ====
module execute_stage import core_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      hold_i,
    input  alu_op_t   op_i,
    input  word_t     a_i,
    input  word_t     b_i,
    input  word_t     store_data_i,
    input  reg_addr_t waddr_i,
    input  logic      we_i,
    input  logic      load_i,
    input  logic      store_i,
    input  word_t     pc_i,
    output word_t     result_o,
    output word_t     mem_result_o,
    output word_t     mem_store_data_o,
    output reg_addr_t mem_waddr_o,
    output logic      mem_we_o,
    output logic      mem_load_o,
    output logic      mem_store_o,
    output word_t     mem_pc_o
);

    always_comb begin
        case (op_i)
            alu_add: result_o = a_i + b_i;  // also load/store address
            alu_sub: result_o = a_i - b_i;
            alu_and: result_o = a_i & b_i;
            alu_or:  result_o = a_i | b_i;
            alu_xor: result_o = a_i ^ b_i;
            alu_slt: result_o = {{(xlen-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            alu_lui: result_o = {b_i[15:0], 16'h0000};
            default: result_o = b_i;
        endcase
    end

    //////////////////////////////////////////
    // execute to memory register
    //////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mem_we_o    <= 1'b0;
            mem_load_o  <= 1'b0;
            mem_store_o <= 1'b0;
        end else if (!hold_i) begin
            mem_we_o    <= we_i;
            mem_load_o  <= load_i;
            mem_store_o <= store_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hold_i) begin
            mem_result_o     <= result_o;
            mem_store_data_o <= store_data_i;
            mem_waddr_o      <= waddr_i;
            mem_pc_o         <= pc_i;
        end
    end

endmodule

// ==== verilog/fetch_stage.sv ====
module fetch_stage import core_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  fetch_hold_i,
    input  logic  inst_stall_i,
    input  logic  branch_taken_i,
    input  word_t branch_target_i,
    input  word_t rom_data_i,
    output logic  rom_ce_o,
    output word_t rom_addr_o,
    output word_t id_pc_o,
    output word_t id_inst_o
);
    word_t pc;
    word_t pending_target;
    logic  pending;
    logic  accept;
    logic  branch_leaves;

    assign rom_addr_o    = pc;
    assign accept        = rom_ce_o & ~inst_stall_i & ~fetch_hold_i;
    assign branch_leaves = branch_taken_i & ~fetch_hold_i;  // pc now points at delay slot

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rom_ce_o <= 1'b0;
            pc       <= reset_pc;
            pending  <= 1'b0;
        end else begin
            rom_ce_o <= 1'b1;
            if (branch_leaves) begin
                if (accept) begin
                    pc <= branch_target_i;
                end else begin
                    pending <= 1'b1;  // redirect once delay slot is in
                end
            end else if (accept) begin
                pc      <= pending ? pending_target : pc + 32'd4;
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (branch_leaves) pending_target <= branch_target_i;
    end

    //////////////////////////////////////////
    // fetch to decode register
    //////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            id_inst_o <= nop_inst;
        end else if (!fetch_hold_i) begin
            id_inst_o <= accept ? rom_data_i : nop_inst;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!fetch_hold_i) id_pc_o <= pc;
    end

    // fetch address holds until the rom takes it
    a_addr_held : assert property (@(posedge clk_i) disable iff (reset_i)
        rom_ce_o && !accept |=> $stable(rom_addr_o))
        else $error("fetch address moved before the fetch was accepted");

endmodule

// ==== verilog/hazard_unit.sv ====
module hazard_unit import core_pkg::*; (
    input  reg_addr_t rs_i,
    input  reg_addr_t rt_i,
    input  logic      rs_read_i,
    input  logic      rt_read_i,
    input  reg_addr_t ex_waddr_i,
    input  logic      ex_load_i,
    input  logic      inst_stall_i,
    input  logic      data_stall_i,
    input  logic      ram_ce_i,
    output logic      fetch_hold_o,
    output logic      decode_hold_o,
    output logic      ex_bubble_o,
    output logic      mem_hold_o,
    output logic      wb_bubble_o,
    output logic      stall_all_o
);
    logic load_use;
    logic mem_stall;

    always_comb begin
        load_use = ex_load_i && ex_waddr_i != '0 &&
                   ((rs_read_i && rs_i == ex_waddr_i) || (rt_read_i && rt_i == ex_waddr_i));
        mem_stall = data_stall_i & ram_ce_i;

        fetch_hold_o  = load_use | mem_stall;
        decode_hold_o = mem_stall;
        ex_bubble_o   = load_use & ~mem_stall;  // memory stall freezes the bubble too
        mem_hold_o    = mem_stall;
        wb_bubble_o   = mem_stall;
        stall_all_o   = fetch_hold_o | inst_stall_i;
    end

endmodule

// ==== verilog/memory_stage.sv ====
module memory_stage import core_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      data_stall_i,
    input  word_t     result_i,
    input  word_t     store_data_i,
    input  reg_addr_t waddr_i,
    input  logic      we_i,
    input  logic      load_i,
    input  logic      store_i,
    input  word_t     pc_i,
    input  word_t     ram_data_i,
    output logic      ram_ce_o,
    output logic      ram_we_o,
    output word_t     ram_addr_o,
    output word_t     ram_wdata_o,
    output word_t     mem_wdata_o,
    output logic      wb_we_o,
    output reg_addr_t wb_waddr_o,
    output word_t     wb_wdata_o,
    output word_t     wb_pc_o
);
    logic stall;

    assign ram_ce_o    = load_i | store_i;
    assign ram_we_o    = store_i;
    assign ram_addr_o  = result_i;
    assign ram_wdata_o = store_data_i;
    assign mem_wdata_o = load_i ? ram_data_i : result_i;
    assign stall       = data_stall_i & ram_ce_o;  // stall only counts with ce up

    //////////////////////////////////////////
    // memory to writeback register
    //////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i || stall) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_waddr_o <= waddr_i;
        wb_wdata_o <= mem_wdata_o;
        wb_pc_o    <= pc_i;
    end

    // a stalled store stays on the port untouched until it completes
    a_store_held : assert property (@(posedge clk_i) disable iff (reset_i)
        ram_we_o && data_stall_i |=> ram_we_o && ram_ce_o && $stable(ram_addr_o))
        else $error("stalled store dropped or moved");

endmodule

// ==== verilog/reg_file.sv ====
module reg_file import core_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);
    word_t regs [1:31];  // $0 has no storage

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule
